// ==== gpio_pkg.sv ====
package gpio_pkg;

    // bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // one digit, active low, dot in bit 0
    typedef logic [7:0]  seg_t;
    typedef logic [3:0]  nibble_t;

    // shared bus owner state
    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

    // register map, compared against paddr[3:0]
    localparam logic [3:0] reg_out_offset = 4'h0;
    localparam logic [3:0] reg_in_offset  = 4'h4;
    localparam logic [3:0] reg_seg_offset = 4'h8;

    // all segments off
    localparam seg_t seg_blank = 8'hff;

endpackage

// ==== seg7_decoder.sv ====
module seg7_decoder (
    input  gpio_pkg::nibble_t num,
    output gpio_pkg::seg_t    seg_out
);
    import gpio_pkg::*;

    // segments a..g in bits 7..1, dot kept off
    always_comb begin
        case (num)
            4'h0: seg_out = 8'b0000_0011;
            4'h1: seg_out = 8'b1001_1111;
            4'h2: seg_out = 8'b0010_0101;
            4'h3: seg_out = 8'b0000_1101;
            4'h4: seg_out = 8'b1001_1001;
            4'h5: seg_out = 8'b0100_1001;
            4'h6: seg_out = 8'b0100_0001;
            4'h7: seg_out = 8'b0001_1111;
            4'h8: seg_out = 8'b0000_0001;
            4'h9: seg_out = 8'b0000_1001;
            4'ha: seg_out = 8'b0001_0001;
            4'hb: seg_out = 8'b1100_0001;
            4'hc: seg_out = 8'b0110_0011;
            4'hd: seg_out = 8'b1000_0101;
            4'he: seg_out = 8'b0110_0001;
            4'hf: seg_out = 8'b0111_0001;
            default: seg_out = seg_blank;
        endcase
    end

endmodule

// ==== apb_arbiter.sv ====
module apb_arbiter (
    input  logic              clock,
    input  logic              reset,

    input  logic              cpu_psel,
    input  logic              cpu_penable,
    input  logic              cpu_pwrite,
    input  gpio_pkg::addr_t   cpu_paddr,
    input  gpio_pkg::data_t   cpu_pwdata,
    input  gpio_pkg::strb_t   cpu_pstrb,
    output logic              cpu_pready,
    output gpio_pkg::data_t   cpu_prdata,
    output logic              cpu_pslverr,

    input  logic              dbg_psel,
    input  logic              dbg_penable,
    input  logic              dbg_pwrite,
    input  gpio_pkg::addr_t   dbg_paddr,
    input  gpio_pkg::data_t   dbg_pwdata,
    input  gpio_pkg::strb_t   dbg_pstrb,
    output logic              dbg_pready,
    output gpio_pkg::data_t   dbg_prdata,
    output logic              dbg_pslverr,

    output logic              bus_psel,
    output logic              bus_penable,
    output logic              bus_pwrite,
    output gpio_pkg::addr_t   bus_paddr,
    output gpio_pkg::data_t   bus_pwdata,
    output gpio_pkg::strb_t   bus_pstrb,
    input  logic              bus_pready,
    input  gpio_pkg::data_t   bus_prdata,
    input  logic              bus_pslverr
);
    import gpio_pkg::*;

    arb_state_t state;
    logic       grant_dbg;
    logic       last_dbg;
    logic       pick_dbg;
    logic       sel_dbg;
    logic       busy;
    logic       cpu_owns;
    logic       dbg_owns;

    assign busy = (state == arb_busy);

    // on a tie the port not granted last wins
    assign pick_dbg = dbg_psel & (~cpu_psel | ~last_dbg);
    assign sel_dbg  = busy ? grant_dbg : pick_dbg;

    always_comb begin
        if (sel_dbg) begin
            bus_psel    = dbg_psel;
            bus_penable = busy & dbg_penable;
            bus_pwrite  = dbg_pwrite;
            bus_paddr   = dbg_paddr;
            bus_pwdata  = dbg_pwdata;
            bus_pstrb   = dbg_pstrb;
        end else begin
            bus_psel    = cpu_psel;
            bus_penable = busy & cpu_penable;
            bus_pwrite  = cpu_pwrite;
            bus_paddr   = cpu_paddr;
            bus_pwdata  = cpu_pwdata;
            bus_pstrb   = cpu_pstrb;
        end
    end

    // response goes back to the owner only
    assign cpu_owns    = busy & ~grant_dbg;
    assign dbg_owns    = busy & grant_dbg;
    assign cpu_pready  = cpu_owns & bus_pready;
    assign cpu_prdata  = cpu_owns ? bus_prdata : '0;
    assign cpu_pslverr = cpu_owns & bus_pslverr;
    assign dbg_pready  = dbg_owns & bus_pready;
    assign dbg_prdata  = dbg_owns ? bus_prdata : '0;
    assign dbg_pslverr = dbg_owns & bus_pslverr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= arb_idle;
            grant_dbg <= 1'b0;
            // so cpu takes the first tie
            last_dbg  <= 1'b1;
        end else begin
            case (state)
                arb_idle: begin
                    if (bus_psel) begin
                        state     <= arb_busy;
                        grant_dbg <= pick_dbg;
                    end
                end
                arb_busy: begin
                    if (bus_penable && bus_pready) begin
                        state    <= arb_idle;
                        last_dbg <= grant_dbg;
                    end else if (!bus_psel) begin
                        // requester dropped out mid transfer
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule

// ==== gpio_regs.sv ====
module gpio_regs #(
    parameter int gpio_width = 16
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  gpio_pkg::addr_t       paddr,
    input  gpio_pkg::data_t       pwdata,
    input  gpio_pkg::strb_t       pstrb,
    output logic                  pready,
    output gpio_pkg::data_t       prdata,
    output logic                  pslverr,

    output logic [gpio_width-1:0] gpio_out,
    input  logic [gpio_width-1:0] gpio_in,

    output gpio_pkg::seg_t        seg_0,
    output gpio_pkg::seg_t        seg_1,
    output gpio_pkg::seg_t        seg_2,
    output gpio_pkg::seg_t        seg_3,
    output gpio_pkg::seg_t        seg_4,
    output gpio_pkg::seg_t        seg_5,
    output gpio_pkg::seg_t        seg_6,
    output gpio_pkg::seg_t        seg_7
);
    import gpio_pkg::*;

    localparam int n_bytes  = gpio_width / 8;
    localparam int n_digits = 8;

    logic [3:0]            offset;
    logic                  hit_out;
    logic                  hit_in;
    logic                  hit_seg;
    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic [gpio_width-1:0] in_meta;
    logic [gpio_width-1:0] in_sync;
    seg_t                  seg_d [n_digits];
    seg_t                  seg_q [n_digits];

    assign offset  = paddr[3:0];
    assign hit_out = (offset == reg_out_offset);
    assign hit_in  = (offset == reg_in_offset);
    assign hit_seg = (offset == reg_seg_offset);

    // no wait states
    assign access  = psel & penable;
    assign pready  = access;
    assign wr_en   = access & pwrite;
    assign rd_en   = psel & ~pwrite;
    assign pslverr = access & ~(hit_out | hit_in | hit_seg);

    // read data valid during the access phase
    always_comb begin
        prdata = '0;
        if (rd_en) begin
            if (hit_out) begin
                prdata = data_t'(gpio_out);
            end else if (hit_in) begin
                prdata = data_t'(in_sync);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            gpio_out <= '0;
        end else if (wr_en && hit_out) begin
            for (int b = 0; b < n_bytes; b++) begin
                if (pstrb[b]) begin
                    gpio_out[b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
    end

    // two-flop input synchronizer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // one decoder per nibble of the write data
    for (genvar i = 0; i < n_digits; i++) begin : g_digit
        seg7_decoder u_dec (
            .num     (pwdata[i*4 +: 4]),
            .seg_out (seg_d[i])
        );
    end

    // byte strobe covers two digits
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int d = 0; d < n_digits; d++) begin
                seg_q[d] <= seg_blank;
            end
        end else if (wr_en && hit_seg) begin
            for (int d = 0; d < n_digits; d++) begin
                if (pstrb[d/2]) begin
                    seg_q[d] <= seg_d[d];
                end
            end
        end
    end

    assign seg_0 = seg_q[0];
    assign seg_1 = seg_q[1];
    assign seg_2 = seg_q[2];
    assign seg_3 = seg_q[3];
    assign seg_4 = seg_q[4];
    assign seg_5 = seg_q[5];
    assign seg_6 = seg_q[6];
    assign seg_7 = seg_q[7];

endmodule

// ==== gpio_subsystem.sv ====
module gpio_subsystem #(
    parameter int gpio_width = 16
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  cpu_psel,
    input  logic                  cpu_penable,
    input  logic                  cpu_pwrite,
    input  gpio_pkg::addr_t       cpu_paddr,
    input  gpio_pkg::data_t       cpu_pwdata,
    input  gpio_pkg::strb_t       cpu_pstrb,
    output logic                  cpu_pready,
    output gpio_pkg::data_t       cpu_prdata,
    output logic                  cpu_pslverr,

    input  logic                  dbg_psel,
    input  logic                  dbg_penable,
    input  logic                  dbg_pwrite,
    input  gpio_pkg::addr_t       dbg_paddr,
    input  gpio_pkg::data_t       dbg_pwdata,
    input  gpio_pkg::strb_t       dbg_pstrb,
    output logic                  dbg_pready,
    output gpio_pkg::data_t       dbg_prdata,
    output logic                  dbg_pslverr,

    output logic [gpio_width-1:0] gpio_out,
    input  logic [gpio_width-1:0] gpio_in,
    output gpio_pkg::seg_t        gpio_seg_0,
    output gpio_pkg::seg_t        gpio_seg_1,
    output gpio_pkg::seg_t        gpio_seg_2,
    output gpio_pkg::seg_t        gpio_seg_3,
    output gpio_pkg::seg_t        gpio_seg_4,
    output gpio_pkg::seg_t        gpio_seg_5,
    output gpio_pkg::seg_t        gpio_seg_6,
    output gpio_pkg::seg_t        gpio_seg_7
);
    import gpio_pkg::*;

    // shared completer side
    logic  bus_psel;
    logic  bus_penable;
    logic  bus_pwrite;
    addr_t bus_paddr;
    data_t bus_pwdata;
    strb_t bus_pstrb;
    logic  bus_pready;
    data_t bus_prdata;
    logic  bus_pslverr;

    apb_arbiter u_arbiter (
        .clock       (clock),
        .reset       (reset),
        .cpu_psel    (cpu_psel),
        .cpu_penable (cpu_penable),
        .cpu_pwrite  (cpu_pwrite),
        .cpu_paddr   (cpu_paddr),
        .cpu_pwdata  (cpu_pwdata),
        .cpu_pstrb   (cpu_pstrb),
        .cpu_pready  (cpu_pready),
        .cpu_prdata  (cpu_prdata),
        .cpu_pslverr (cpu_pslverr),
        .dbg_psel    (dbg_psel),
        .dbg_penable (dbg_penable),
        .dbg_pwrite  (dbg_pwrite),
        .dbg_paddr   (dbg_paddr),
        .dbg_pwdata  (dbg_pwdata),
        .dbg_pstrb   (dbg_pstrb),
        .dbg_pready  (dbg_pready),
        .dbg_prdata  (dbg_prdata),
        .dbg_pslverr (dbg_pslverr),
        .bus_psel    (bus_psel),
        .bus_penable (bus_penable),
        .bus_pwrite  (bus_pwrite),
        .bus_paddr   (bus_paddr),
        .bus_pwdata  (bus_pwdata),
        .bus_pstrb   (bus_pstrb),
        .bus_pready  (bus_pready),
        .bus_prdata  (bus_prdata),
        .bus_pslverr (bus_pslverr)
    );

    gpio_regs #(
        .gpio_width (gpio_width)
    ) u_regs (
        .clock    (clock),
        .reset    (reset),
        .psel     (bus_psel),
        .penable  (bus_penable),
        .pwrite   (bus_pwrite),
        .paddr    (bus_paddr),
        .pwdata   (bus_pwdata),
        .pstrb    (bus_pstrb),
        .pready   (bus_pready),
        .prdata   (bus_prdata),
        .pslverr  (bus_pslverr),
        .gpio_out (gpio_out),
        .gpio_in  (gpio_in),
        .seg_0    (gpio_seg_0),
        .seg_1    (gpio_seg_1),
        .seg_2    (gpio_seg_2),
        .seg_3    (gpio_seg_3),
        .seg_4    (gpio_seg_4),
        .seg_5    (gpio_seg_5),
        .seg_6    (gpio_seg_6),
        .seg_7    (gpio_seg_7)
    );

endmodule

// ==== gpio_assertions.sv ====
module gpio_assertions (
    input logic                 clock,
    input logic                 reset,
    input gpio_pkg::arb_state_t state,
    input logic                 bus_psel,
    input logic                 bus_penable,
    input gpio_pkg::addr_t      bus_paddr,
    input gpio_pkg::data_t      bus_pwdata,
    input gpio_pkg::data_t      cpu_pwdata,
    input gpio_pkg::data_t      dbg_pwdata,
    input logic                 cpu_pready,
    input logic                 dbg_pready
);
    timeunit 1ns;
    timeprecision 100ps;
    import gpio_pkg::*;

    int unsigned fail_count = 0;

    // completer never sees an access phase without select
    enable_has_select: assert property (@(posedge clock) disable iff (reset)
        bus_penable |-> bus_psel)
    else begin
        $error("bus_penable high while bus_psel is low");
        fail_count++;
    end

    // requester picked in the setup cycle keeps the bus into the access phase
    grant_held_while_busy: assert property (@(posedge clock) disable iff (reset)
        (state == arb_idle && bus_psel) |=> ($stable(bus_paddr) && $stable(bus_pwdata)))
    else begin
        $error("grant changed between setup and access");
        fail_count++;
    end

    // pready only to the port whose transfer is on the bus
    one_pready: assert property (@(posedge clock) disable iff (reset)
        !(cpu_pready && dbg_pready)
        && (!cpu_pready || (bus_pwdata == cpu_pwdata))
        && (!dbg_pready || (bus_pwdata == dbg_pwdata)))
    else begin
        $error("pready high for a port that does not own the bus");
        fail_count++;
    end

endmodule

bind apb_arbiter gpio_assertions arb_checks (
    .clock       (clock),
    .reset       (reset),
    .state       (state),
    .bus_psel    (bus_psel),
    .bus_penable (bus_penable),
    .bus_paddr   (bus_paddr),
    .bus_pwdata  (bus_pwdata),
    .cpu_pwdata  (cpu_pwdata),
    .dbg_pwdata  (dbg_pwdata),
    .cpu_pready  (cpu_pready),
    .dbg_pready  (dbg_pready)
);

// ==== tb_gpio_subsystem.sv ====
module tb_gpio_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import gpio_pkg::*;

    localparam int gpio_width = 16;
    localparam bit cpu_port = 1'b0;
    localparam bit dbg_port = 1'b1;
    localparam bit rd = 1'b0;
    localparam bit wr = 1'b1;

    // active low, a..g in bits 7..1, dot off
    localparam seg_t seg_table [16] = '{
        8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49, 8'h41, 8'h1f,
        8'h01, 8'h09, 8'h11, 8'hc1, 8'h63, 8'h85, 8'h61, 8'h71
    };

    logic clock = 1'b0;
    logic reset;
    logic cpu_psel, cpu_penable, cpu_pwrite, cpu_pready, cpu_pslverr;
    logic dbg_psel, dbg_penable, dbg_pwrite, dbg_pready, dbg_pslverr;
    addr_t cpu_paddr, dbg_paddr;
    data_t cpu_pwdata, cpu_prdata, dbg_pwdata, dbg_prdata;
    strb_t cpu_pstrb, dbg_pstrb;
    logic [gpio_width-1:0] gpio_out;
    logic [gpio_width-1:0] gpio_in;
    seg_t seg_act [8];

    // stimulus table
    bit                    t_port [$];
    bit                    t_write [$];
    logic [3:0]            t_offset [$];
    data_t                 t_data [$];
    strb_t                 t_strb [$];
    logic [gpio_width-1:0] t_gin [$];
    data_t                 t_rdata [$];
    bit                    t_err [$];
    string                 t_name [$];
    bit                    table_ready = 1'b0;

    // expected pin state
    logic [gpio_width-1:0] exp_out;
    seg_t                  exp_seg [8];
    bit                    last_dbg_port;
    integer                seed = 32'he773_6887;

    gpio_subsystem #(
        .gpio_width (gpio_width)
    ) uut (
        .clock       (clock),
        .reset       (reset),
        .cpu_psel    (cpu_psel),
        .cpu_penable (cpu_penable),
        .cpu_pwrite  (cpu_pwrite),
        .cpu_paddr   (cpu_paddr),
        .cpu_pwdata  (cpu_pwdata),
        .cpu_pstrb   (cpu_pstrb),
        .cpu_pready  (cpu_pready),
        .cpu_prdata  (cpu_prdata),
        .cpu_pslverr (cpu_pslverr),
        .dbg_psel    (dbg_psel),
        .dbg_penable (dbg_penable),
        .dbg_pwrite  (dbg_pwrite),
        .dbg_paddr   (dbg_paddr),
        .dbg_pwdata  (dbg_pwdata),
        .dbg_pstrb   (dbg_pstrb),
        .dbg_pready  (dbg_pready),
        .dbg_prdata  (dbg_prdata),
        .dbg_pslverr (dbg_pslverr),
        .gpio_out    (gpio_out),
        .gpio_in     (gpio_in),
        .gpio_seg_0  (seg_act[0]),
        .gpio_seg_1  (seg_act[1]),
        .gpio_seg_2  (seg_act[2]),
        .gpio_seg_3  (seg_act[3]),
        .gpio_seg_4  (seg_act[4]),
        .gpio_seg_5  (seg_act[5]),
        .gpio_seg_6  (seg_act[6]),
        .gpio_seg_7  (seg_act[7])
    );

    always #50 clock = ~clock;

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "segment mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic cpu_transfer(input bit write, input addr_t addr, input data_t data,
                                input strb_t strb, output data_t rdata, output logic err);
        @(posedge clock);
        cpu_psel    <= 1'b1;
        cpu_penable <= 1'b0;
        cpu_pwrite  <= write;
        cpu_paddr   <= addr;
        cpu_pwdata  <= data;
        cpu_pstrb   <= strb;
        @(posedge clock);
        cpu_penable <= 1'b1;
        @(negedge clock);
        while (!cpu_pready) begin
            @(negedge clock);
        end
        rdata = cpu_prdata;
        err   = cpu_pslverr;
        @(posedge clock);
        cpu_psel    <= 1'b0;
        cpu_penable <= 1'b0;
    endtask

    task automatic dbg_transfer(input bit write, input addr_t addr, input data_t data,
                                input strb_t strb, output data_t rdata, output logic err);
        @(posedge clock);
        dbg_psel    <= 1'b1;
        dbg_penable <= 1'b0;
        dbg_pwrite  <= write;
        dbg_paddr   <= addr;
        dbg_pwdata  <= data;
        dbg_pstrb   <= strb;
        @(posedge clock);
        dbg_penable <= 1'b1;
        @(negedge clock);
        while (!dbg_pready) begin
            @(negedge clock);
        end
        rdata = dbg_prdata;
        err   = dbg_pslverr;
        @(posedge clock);
        dbg_psel    <= 1'b0;
        dbg_penable <= 1'b0;
    endtask

    task automatic add_entry(input bit port, input bit write, input logic [3:0] offset,
                             input data_t data, input strb_t strb,
                             input logic [gpio_width-1:0] gin, input data_t rdata,
                             input bit err, input string name);
        t_port.push_back(port);
        t_write.push_back(write);
        t_offset.push_back(offset);
        t_data.push_back(data);
        t_strb.push_back(strb);
        t_gin.push_back(gin);
        t_rdata.push_back(rdata);
        t_err.push_back(err);
        t_name.push_back(name);
    endtask

    task automatic build_table();
        logic [gpio_width-1:0] g [13];
        logic [31:0]           rnd;
        for (int k = 0; k < 13; k++) begin
            rnd  = $random(seed);
            g[k] = rnd[gpio_width-1:0];
        end
        add_entry(cpu_port, wr, 4'h0, 32'h0000_a5c3, 4'b0011, g[0], 32'h0, 1'b0,
                  "cpu write out");
        add_entry(dbg_port, wr, 4'h0, 32'h0000_7e11, 4'b0010, g[1], 32'h0, 1'b0,
                  "dbg write out high byte");
        add_entry(cpu_port, rd, 4'h0, 32'h0, 4'b0000, g[2], 32'h0000_7ec3, 1'b0,
                  "cpu read out");
        add_entry(dbg_port, wr, 4'h0, 32'h1234_5699, 4'b0101, g[3], 32'h0, 1'b0,
                  "dbg write out low byte");
        add_entry(dbg_port, rd, 4'h0, 32'h0, 4'b0000, g[4], 32'h0000_7e99, 1'b0,
                  "dbg read out");
        add_entry(cpu_port, rd, 4'h4, 32'h0, 4'b0000, g[5], data_t'(g[5]), 1'b0,
                  "cpu read in 1");
        add_entry(dbg_port, rd, 4'h4, 32'h0, 4'b0000, g[6], data_t'(g[6]), 1'b0,
                  "dbg read in");
        add_entry(cpu_port, rd, 4'h4, 32'h0, 4'b0000, g[7], data_t'(g[7]), 1'b0,
                  "cpu read in 2");
        add_entry(cpu_port, wr, 4'h8, 32'h89ab_cdef, 4'b1111, g[8], 32'h0, 1'b0,
                  "cpu write display");
        add_entry(dbg_port, wr, 4'h8, 32'h0123_4567, 4'b0101, g[9], 32'h0, 1'b0,
                  "dbg write display bytes 0 and 2");
        add_entry(cpu_port, rd, 4'h8, 32'h0, 4'b0000, g[10], 32'h0, 1'b0,
                  "cpu read display");
        add_entry(cpu_port, wr, 4'hc, 32'h0000_ffff, 4'b1111, g[11], 32'h0, 1'b1,
                  "cpu write unmapped");
        add_entry(dbg_port, rd, 4'hc, 32'h0, 4'b0000, g[12], 32'h0, 1'b1,
                  "dbg read unmapped");
    endtask

    task automatic update_model(input logic [3:0] offset, input data_t data, input strb_t strb);
        if (offset == reg_out_offset) begin
            for (int b = 0; b < gpio_width / 8; b++) begin
                if (strb[b]) begin
                    exp_out[b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else if (offset == reg_seg_offset) begin
            for (int d = 0; d < 8; d++) begin
                if (strb[d/2]) begin
                    exp_seg[d] = seg_table[data[d*4 +: 4]];
                end
            end
        end
    endtask

    task automatic check_outputs(input string name);
        check_data({name, ", gpio_out"}, data_t'(exp_out), data_t'(gpio_out));
        for (int d = 0; d < 8; d++) begin
            check_seg($sformatf("%s, digit %0d", name, d), exp_seg[d], seg_act[d]);
        end
    endtask

    task automatic apply_entry(input int i);
        data_t rdata;
        logic  err;
        @(posedge clock);
        gpio_in <= t_gin[i];
        repeat (2) @(posedge clock);
        if (t_port[i] == dbg_port) begin
            dbg_transfer(t_write[i], {28'h0, t_offset[i]}, t_data[i], t_strb[i], rdata, err);
        end else begin
            cpu_transfer(t_write[i], {28'h0, t_offset[i]}, t_data[i], t_strb[i], rdata, err);
        end
        last_dbg_port = t_port[i];
        if (t_write[i] && !t_err[i]) begin
            update_model(t_offset[i], t_data[i], t_strb[i]);
        end
        if (!t_write[i] && !t_err[i]) begin
            check_data(t_name[i], t_rdata[i], rdata);
        end
        check_flag({t_name[i], ", pslverr"}, t_err[i], err);
        @(negedge clock);
        check_outputs(t_name[i]);
    endtask

    task automatic contend_writes(input string name, input data_t cpu_data, input data_t dbg_data);
        data_t cpu_rd;
        data_t dbg_rd;
        logic  cpu_err;
        logic  dbg_err;
        // winner is the port not granted last, the loser writes last
        if (last_dbg_port) begin
            update_model(reg_out_offset, cpu_data, 4'b1111);
            update_model(reg_out_offset, dbg_data, 4'b1111);
        end else begin
            update_model(reg_out_offset, dbg_data, 4'b1111);
            update_model(reg_out_offset, cpu_data, 4'b1111);
        end
        fork
            cpu_transfer(wr, 32'h0, cpu_data, 4'b1111, cpu_rd, cpu_err);
            dbg_transfer(wr, 32'h0, dbg_data, 4'b1111, dbg_rd, dbg_err);
        join
        check_flag({name, ", cpu pslverr"}, 1'b0, cpu_err);
        check_flag({name, ", dbg pslverr"}, 1'b0, dbg_err);
        @(negedge clock);
        check_outputs(name);
    endtask

    initial begin
        wait (table_ready);
        // ten cycles per step, the contests and read-back count as three more
        #((t_name.size() + 3) * 10 * 100 + 2000);
        $display("Error: simulation timed out waiting for the DUT");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        data_t rdata;
        logic  err;
        reset       <= 1'b1;
        cpu_psel    <= 1'b0;
        cpu_penable <= 1'b0;
        cpu_pwrite  <= 1'b0;
        cpu_paddr   <= '0;
        cpu_pwdata  <= '0;
        cpu_pstrb   <= '0;
        dbg_psel    <= 1'b0;
        dbg_penable <= 1'b0;
        dbg_pwrite  <= 1'b0;
        dbg_paddr   <= '0;
        dbg_pwdata  <= '0;
        dbg_pstrb   <= '0;
        gpio_in     <= '0;
        exp_out = '0;
        for (int d = 0; d < 8; d++) begin
            exp_seg[d] = seg_blank;
        end
        // after reset cpu counts as not granted last
        last_dbg_port = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_outputs("reset values");
        check_flag("reset cpu_pready", 1'b0, cpu_pready);
        check_flag("reset dbg_pready", 1'b0, dbg_pready);
        for (int i = 0; i < t_name.size(); i++) begin
            apply_entry(i);
        end
        contend_writes("first contest", 32'h0000_c0de, 32'h0000_d1a9);
        cpu_transfer(rd, 32'h0, 32'h0, 4'b0000, rdata, err);
        last_dbg_port = cpu_port;
        check_data("read after first contest", data_t'(exp_out), rdata);
        contend_writes("second contest", 32'h0000_3c5a, 32'h0000_b00f);
        if (uut.u_arbiter.arb_checks.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "arbiter assertions fired");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
gpio_pkg.sv
seg7_decoder.sv
apb_arbiter.sv
gpio_regs.sv
gpio_subsystem.sv
gpio_assertions.sv
tb_gpio_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gpio subsystem testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_gpio_subsystem \
    -f flist.f -o tb_gpio_subsystem || exit 1
./obj_dir/tb_gpio_subsystem > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && echo "FAIL" && exit 1
grep -q "Test passed" sim.log && echo "PASS" && exit 0
echo "FAIL: no result in sim.log"
exit 1
